// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP      := tb_cmd_uart
FLIST    := build.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
RUN_ARGS := +verilator+error+limit+1000
SRCS     := $(wildcard source/*.sv testbench/*.sv)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@./$(BIN) $(RUN_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: build.f
source/cmd_uart_pkg.sv
source/uart_rx.sv
source/frame_ctrl.sv
source/channel_regs.sv
source/resp_queue.sv
source/uart_tx.sv
source/cmd_uart_top.sv
testbench/cmd_uart_asserts.sv
testbench/tb_cmd_uart.sv

// File: source/channel_regs.sv
`timescale 1ns/1ps
`default_nettype none

module channel_regs (
	input wire clk,
	input wire nrst,
	input wire cmd_uart_pkg::reg_wr_t wr,
	input wire cmd_uart_pkg::chan_idx_t rd_chan,
	output cmd_uart_pkg::chan_cfg_t rd_cfg,
	output cmd_uart_pkg::chan_cfg_t [3:0] cfg
);
	import cmd_uart_pkg::*;

	// trigger disabled, level and vector cleared
	localparam chan_cfg_t CFG_RESET = '{trig_type: 2'd3, trig_level: 8'h00, vect_value: 8'h00};

	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			for (int i = 0; i < 4; i++)
				cfg[i] <= CFG_RESET;
		end else if (wr.en) begin
			if (wr.is_vect) begin
				cfg[wr.chan].vect_value <= wr.value;
			end else begin
				cfg[wr.chan].trig_type <= wr.trig_type;
				cfg[wr.chan].trig_level <= wr.value;
			end
		end
	end

	assign rd_cfg = cfg[rd_chan];  // combinational readback

endmodule

`default_nettype wire

// File: source/cmd_uart_pkg.sv
`default_nettype none

package cmd_uart_pkg;

	typedef logic [7:0] byte_t;       // one serial data byte
	typedef logic [1:0] chan_idx_t;
	typedef logic [1:0] baud_sel_t;   // 0 slowest .. 3 fastest
	typedef logic [1:0] trig_type_t;  // 3 means disabled

	// command as received, op arrives first
	typedef struct packed {
		byte_t op;
		byte_t chan;
		byte_t arg;
		byte_t value;
	} cmd_frame_t;

	typedef struct packed {
		trig_type_t trig_type;
		byte_t      trig_level;
		byte_t      vect_value;
	} chan_cfg_t;

	typedef struct packed {
		logic       en;
		chan_idx_t  chan;
		logic       is_vect;    // vector write, else trigger write
		trig_type_t trig_type;
		byte_t      value;      // level or vector
	} reg_wr_t;

	localparam byte_t OP_TRIG_WR = 8'h53;
	localparam byte_t OP_TRIG_RD = 8'h5C;
	localparam byte_t OP_VECT_WR = 8'hA5;
	localparam byte_t OP_VECT_RD = 8'h00;

	// bit period = base divisor * multiplier, indexed by baud_sel_t
	localparam int BAUD_MULT [4] = '{88, 16, 4, 1};

	localparam byte_t RESP_ERR = 8'hFF;
	localparam int FRAME_BYTES = 4;
	localparam int TIMEOUT_BITS = 16;  // idle bit times before a partial frame is dropped

endpackage

`default_nettype wire

// File: source/cmd_uart_top.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_uart_top #(
	parameter int BASE_DIV = 5208,  // 50 MHz clock at 9600 baud
	parameter int RESP_DEPTH = 8
) (
	input wire clk,
	input wire nrst,
	input wire cmd_uart_pkg::baud_sel_t baud,
	input wire rx,
	output wire tx,
	output wire cmd_uart_pkg::chan_cfg_t [3:0] cfg
);
	import cmd_uart_pkg::*;

	logic rx_valid;
	byte_t rx_data;
	reg_wr_t wr;
	chan_idx_t rd_chan;
	chan_cfg_t rd_cfg;
	logic push;
	byte_t push_data;
	logic pop;     // also the credit return
	byte_t q_data;
	logic q_empty;

	uart_rx #(.BASE_DIV(BASE_DIV)) u_rx (
		.clk(clk), .nrst(nrst), .rx(rx), .baud(baud),
		.rx_valid(rx_valid), .rx_data(rx_data)
	);

	frame_ctrl #(.BASE_DIV(BASE_DIV), .RESP_DEPTH(RESP_DEPTH)) u_ctrl (
		.clk(clk), .nrst(nrst), .baud(baud),
		.rx_valid(rx_valid), .rx_data(rx_data),
		.wr(wr), .rd_chan(rd_chan), .rd_cfg(rd_cfg),
		.credit_return(pop), .push(push), .push_data(push_data)
	);

	channel_regs u_regs (
		.clk(clk), .nrst(nrst), .wr(wr),
		.rd_chan(rd_chan), .rd_cfg(rd_cfg), .cfg(cfg)
	);

	resp_queue #(.RESP_DEPTH(RESP_DEPTH)) u_queue (
		.clk(clk), .nrst(nrst), .push(push), .push_data(push_data),
		.pop(pop), .data(q_data), .empty(q_empty)
	);

	uart_tx #(.BASE_DIV(BASE_DIV)) u_tx (
		.clk(clk), .nrst(nrst), .baud(baud), .empty(q_empty),
		.data(q_data), .pop(pop), .tx(tx)
	);

endmodule

`default_nettype wire

// File: source/frame_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module frame_ctrl #(
	parameter int BASE_DIV = 4,
	parameter int RESP_DEPTH = 8
) (
	input wire clk,
	input wire nrst,
	input wire cmd_uart_pkg::baud_sel_t baud,
	input wire rx_valid,
	input wire cmd_uart_pkg::byte_t rx_data,
	output cmd_uart_pkg::reg_wr_t wr,
	output cmd_uart_pkg::chan_idx_t rd_chan,
	input wire cmd_uart_pkg::chan_cfg_t rd_cfg,
	input wire credit_return,
	output logic push,
	output cmd_uart_pkg::byte_t push_data
);
	import cmd_uart_pkg::*;

	localparam int TO_MAX = BASE_DIV * BAUD_MULT[0] * TIMEOUT_BITS;
	localparam int TO_W = $clog2(TO_MAX + 1);
	localparam int CR_W = $clog2(RESP_DEPTH + 1);

	typedef enum logic [1:0] {COLLECT, DECODE, WAIT_CREDIT, RESPOND} fc_state_t;

	fc_state_t state;
	cmd_frame_t frame;
	cmd_frame_t resp;   // op slot is the next byte to push
	logic [1:0] byte_cnt;
	logic [1:0] push_cnt;
	logic [TO_W-1:0] gap_cnt;
	logic [TO_W-1:0] gap_lim;
	logic [CR_W-1:0] credits;
	logic op_ok;
	logic type_ok;
	logic frame_ok;
	logic is_write;

	assign gap_lim = TO_W'(BASE_DIV * BAUD_MULT[baud] * TIMEOUT_BITS);

	always_comb begin
		op_ok = frame.op inside {OP_TRIG_WR, OP_TRIG_RD, OP_VECT_WR, OP_VECT_RD};
		type_ok = (frame.op != OP_TRIG_WR) || (frame.arg < 8'd3);
		frame_ok = op_ok && type_ok && (frame.chan < 8'd4);
		is_write = (frame.op == OP_TRIG_WR) || (frame.op == OP_VECT_WR);
	end

	assign rd_chan = frame.chan[1:0];
	assign wr.en = (state == DECODE) && frame_ok && is_write;  // one cycle only
	assign wr.chan = frame.chan[1:0];
	assign wr.is_vect = frame.op == OP_VECT_WR;
	assign wr.trig_type = frame.arg[1:0];
	assign wr.value = frame.value;
	assign push = state == RESPOND;
	assign push_data = resp.op;

	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			state <= COLLECT;
			byte_cnt <= '0;
			push_cnt <= '0;
			gap_cnt <= '0;
		end else begin
			case (state)
				COLLECT: begin
					if (rx_valid) begin
						gap_cnt <= '0;
						byte_cnt <= byte_cnt + 2'd1;  // wraps to 0 on the last byte
						if (byte_cnt == 2'(FRAME_BYTES - 1))
							state <= DECODE;
					end else if (byte_cnt != 2'd0) begin
						gap_cnt <= gap_cnt + 1'b1;
						if (gap_cnt == gap_lim - 1'b1) begin
							byte_cnt <= '0;  // line went quiet mid-frame
							gap_cnt <= '0;
						end
					end
				end
				DECODE: state <= WAIT_CREDIT;
				WAIT_CREDIT: begin
					// whole response must fit before the first push
					if (credits >= CR_W'(FRAME_BYTES)) begin
						push_cnt <= '0;
						state <= RESPOND;
					end
				end
				RESPOND: begin
					push_cnt <= push_cnt + 2'd1;
					if (push_cnt == 2'(FRAME_BYTES - 1))
						state <= COLLECT;
				end
				default: state <= COLLECT;
			endcase
		end
	end

	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst)
			credits <= CR_W'(RESP_DEPTH);
		else
			credits <= credits - CR_W'(push) + CR_W'(credit_return);
	end

	always_ff @(posedge clk) begin
		if (state == COLLECT && rx_valid)
			frame <= {frame[23:0], rx_data};
		if (state == DECODE) begin
			if (!frame_ok)
				resp <= {FRAME_BYTES{RESP_ERR}};
			else if (frame.op == OP_TRIG_RD)
				resp <= {frame.op, frame.chan, 6'd0, rd_cfg.trig_type, rd_cfg.trig_level};
			else if (frame.op == OP_VECT_RD)
				resp <= {frame.op, frame.chan, frame.arg, rd_cfg.vect_value};
			else
				resp <= frame;  // writes echo
		end else if (push) begin
			resp <= {resp[23:0], 8'h00};
		end
	end

endmodule

`default_nettype wire

// File: source/resp_queue.sv
`timescale 1ns/1ps
`default_nettype none

module resp_queue #(
	parameter int RESP_DEPTH = 8
) (
	input wire clk,
	input wire nrst,
	input wire push,
	input wire cmd_uart_pkg::byte_t push_data,
	input wire pop,
	output cmd_uart_pkg::byte_t data,
	output logic empty
);
	import cmd_uart_pkg::*;

	localparam int PTR_W = $clog2(RESP_DEPTH);
	localparam int CNT_W = $clog2(RESP_DEPTH + 1);

	byte_t mem [RESP_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	// depth need not be a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(RESP_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			count <= count + CNT_W'(push) - CNT_W'(pop);
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

	assign data = mem[rd_ptr];  // oldest byte
	assign empty = count == '0;

endmodule

`default_nettype wire

// File: source/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
	parameter int BASE_DIV = 4
) (
	input wire clk,
	input wire nrst,
	input wire rx,
	input wire cmd_uart_pkg::baud_sel_t baud,
	output logic rx_valid,
	output cmd_uart_pkg::byte_t rx_data
);
	import cmd_uart_pkg::*;

	localparam int MAX_DIV = BASE_DIV * BAUD_MULT[0];
	localparam int DIV_W = $clog2(MAX_DIV + 1);

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

	rx_state_t state;
	logic [1:0] rx_sync;
	logic rx_s;
	logic [DIV_W-1:0] bit_div;
	logic [DIV_W-1:0] half_div;
	logic [DIV_W-1:0] cnt;
	logic [2:0] bit_idx;
	byte_t shreg;
	logic bit_end;

	assign rx_s = rx_sync[1];
	assign bit_div = DIV_W'(BASE_DIV * BAUD_MULT[baud]);
	assign half_div = bit_div >> 1;
	assign bit_end = cnt == bit_div - 1'b1;
	assign rx_data = shreg;

	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			rx_sync <= 2'b11;  // line idles high
			state <= RX_IDLE;
			cnt <= '0;
			bit_idx <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_sync <= {rx_sync[0], rx};
			rx_valid <= 1'b0;
			cnt <= cnt + 1'b1;
			case (state)
				RX_IDLE: begin
					cnt <= '0;
					if (!rx_s)
						state <= RX_START;
				end
				RX_START: begin
					// middle of start bit, a glitch goes back to idle
					if (cnt == half_div) begin
						cnt <= '0;
						bit_idx <= '0;
						state <= rx_s ? RX_IDLE : RX_DATA;
					end
				end
				RX_DATA: begin
					if (bit_end) begin
						cnt <= '0;
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == 3'd7)
							state <= RX_STOP;
					end
				end
				RX_STOP: begin
					if (bit_end) begin
						rx_valid <= rx_s;  // bad stop bit drops the byte
						state <= RX_IDLE;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// lsb first, so new bits enter at the top
	always_ff @(posedge clk) begin
		if (state == RX_DATA && bit_end)
			shreg <= {rx_s, shreg[7:1]};
	end

endmodule

`default_nettype wire

// File: source/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
	parameter int BASE_DIV = 4
) (
	input wire clk,
	input wire nrst,
	input wire cmd_uart_pkg::baud_sel_t baud,
	input wire empty,
	input wire cmd_uart_pkg::byte_t data,
	output logic pop,
	output logic tx
);
	import cmd_uart_pkg::*;

	localparam int MAX_DIV = BASE_DIV * BAUD_MULT[0];
	localparam int DIV_W = $clog2(MAX_DIV + 1);

	typedef enum logic {TX_IDLE, TX_SEND} tx_state_t;

	tx_state_t state;
	logic [DIV_W-1:0] bit_div;
	logic [DIV_W-1:0] cnt;
	logic [3:0] bit_idx;
	logic [9:0] shreg;  // stop, data, start
	logic bit_end;
	logic frame_end;

	assign bit_div = DIV_W'(BASE_DIV * BAUD_MULT[baud]);
	assign bit_end = (state == TX_SEND) && (cnt == bit_div - 1'b1);
	assign frame_end = bit_end && (bit_idx == 4'd9);

	// back to back bytes start right after the stop bit
	assign pop = !empty && ((state == TX_IDLE) || frame_end);
	assign tx = shreg[0];

	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			state <= TX_IDLE;
			cnt <= '0;
			bit_idx <= '0;
			shreg <= '1;  // line high
		end else if (pop) begin
			state <= TX_SEND;
			cnt <= '0;
			bit_idx <= '0;
			shreg <= {1'b1, data, 1'b0};
		end else if (frame_end) begin
			state <= TX_IDLE;
			shreg <= '1;
		end else if (bit_end) begin
			cnt <= '0;
			bit_idx <= bit_idx + 4'd1;
			shreg <= {1'b1, shreg[9:1]};
		end else if (state == TX_SEND) begin
			cnt <= cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: testbench/cmd_uart_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_uart_asserts #(
	parameter int RESP_DEPTH = 8
) (
	input wire clk,
	input wire nrst,
	input wire [$clog2(RESP_DEPTH + 1)-1:0] credits,
	input wire push,
	input wire wr_en
);
	int fail_cnt = 0;  // failure tally

	credit_limit: assert property (@(posedge clk) disable iff (!nrst) credits <= RESP_DEPTH)
		else begin
			$error("credit count above queue depth");
			fail_cnt++;
		end

	// a push spends a credit that must exist
	push_credit: assert property (@(posedge clk) disable iff (!nrst) push |-> credits != 0)
		else begin
			$error("push with no credit left");
			fail_cnt++;
		end

	wr_pulse: assert property (@(posedge clk) disable iff (!nrst) wr_en |=> !wr_en)
		else begin
			$error("register write enable held longer than one cycle");
			fail_cnt++;
		end

endmodule

bind frame_ctrl cmd_uart_asserts #(.RESP_DEPTH(RESP_DEPTH)) u_asserts (
	.clk(clk), .nrst(nrst), .credits(credits), .push(push), .wr_en(wr.en)
);

`default_nettype wire

// File: testbench/tb_cmd_uart.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cmd_uart;
	import cmd_uart_pkg::*;

	localparam int BASE_DIV = 4;

	logic clk;
	logic nrst;
	logic rx;
	logic tx;
	baud_sel_t baud;
	chan_cfg_t [3:0] cfg;

	integer seed = 32'h9dcba4e9;
	int checks = 0;
	int errors = 0;
	byte_t tx_q [$];  // bytes seen on tx

	// reference model of the channel registers
	trig_type_t m_type [4];
	byte_t m_level [4];
	byte_t m_vect [4];

	cmd_uart_top #(.BASE_DIV(BASE_DIV), .RESP_DEPTH(8)) u_dut (
		.clk(clk), .nrst(nrst), .baud(baud), .rx(rx), .tx(tx), .cfg(cfg)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic int bit_cycles();
		return BASE_DIV * BAUD_MULT[baud];
	endfunction

	function automatic byte_t rand_byte();
		return byte_t'($random(seed));
	endfunction

	function automatic int unsigned rand_below(input int unsigned n);
		return {$random(seed)} % n;
	endfunction

	// expected response, model updated as a side effect
	function automatic cmd_frame_t model_cmd(input cmd_frame_t f);
		cmd_frame_t r;
		logic good;
		good = (f.op == OP_TRIG_WR || f.op == OP_TRIG_RD || f.op == OP_VECT_WR
			|| f.op == OP_VECT_RD) && (f.chan < 8'd4);
		if (f.op == OP_TRIG_WR && f.arg >= 8'd3)
			good = 1'b0;  // type 3 is not writable
		r = f;
		if (!good) begin
			r = {4{RESP_ERR}};
		end else if (f.op == OP_TRIG_WR) begin
			m_type[f.chan[1:0]] = f.arg[1:0];
			m_level[f.chan[1:0]] = f.value;
		end else if (f.op == OP_VECT_WR) begin
			m_vect[f.chan[1:0]] = f.value;
		end else if (f.op == OP_TRIG_RD) begin
			r.arg = {6'd0, m_type[f.chan[1:0]]};
			r.value = m_level[f.chan[1:0]];
		end else begin
			r.value = m_vect[f.chan[1:0]];
		end
		return r;
	endfunction

	task automatic check8(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("CHECK FAILED t=%0t %s got %02h expected %02h", $time, name, got, exp);
		end
	endtask

	task automatic check_cfg();
		for (int i = 0; i < 4; i++) begin
			check8($sformatf("cfg[%0d].trig_type", i), 8'(cfg[i].trig_type), 8'(m_type[i]));
			check8($sformatf("cfg[%0d].trig_level", i), cfg[i].trig_level, m_level[i]);
			check8($sformatf("cfg[%0d].vect_value", i), cfg[i].vect_value, m_vect[i]);
		end
	endtask

	task automatic send_byte(input byte_t b);
		logic [9:0] bits;
		bits = {1'b1, b, 1'b0};  // stop, data lsb first, start
		for (int i = 0; i < 10; i++) begin
			rx <= bits[i];
			repeat (bit_cycles()) @(posedge clk);
		end
	endtask

	task automatic send_frame(input cmd_frame_t f);
		send_byte(f.op);
		send_byte(f.chan);
		send_byte(f.arg);
		send_byte(f.value);
	endtask

	// decode n bytes from tx, sampled mid bit on falling edges
	task automatic collect_bytes(input int n);
		int bc;
		int wait_cnt;
		byte_t b;
		bc = bit_cycles();
		for (int k = 0; k < n; k++) begin
			wait_cnt = 0;
			@(negedge clk);
			while (tx !== 1'b0 && wait_cnt < 64 * bc) begin
				@(negedge clk);
				wait_cnt++;
			end
			if (tx !== 1'b0) begin
				errors++;
				$display("timeout waiting for start bit of response byte %0d at t=%0t", k, $time);
				return;
			end
			repeat (bc / 2) @(negedge clk);
			for (int i = 0; i < 8; i++) begin
				repeat (bc) @(negedge clk);
				b[i] = tx;
			end
			repeat (bc) @(negedge clk);
			assert (tx === 1'b1) else begin
				errors++;
				$display("response byte %0d has no stop bit at t=%0t", k, $time);
			end
			tx_q.push_back(b);
		end
	endtask

	task automatic expect_idle(input int cycles);
		int bad;
		bad = 0;
		repeat (cycles) begin
			@(negedge clk);
			if (tx !== 1'b1)
				bad++;
		end
		@(posedge clk);
		assert (bad == 0) else begin
			errors++;
			$display("tx was active when it should be idle, t=%0t", $time);
		end
	endtask

	task automatic do_cmd(input cmd_frame_t f);
		cmd_frame_t exp;
		exp = model_cmd(f);
		tx_q.delete();
		fork
			send_frame(f);
			collect_bytes(FRAME_BYTES);
		join
		expect_idle(2 * bit_cycles());  // no extra bytes, line quiet again
		assert (tx_q.size() == FRAME_BYTES) else begin
			errors++;
			$display("response had %0d bytes instead of 4 at t=%0t", tx_q.size(), $time);
		end
		for (int k = 0; k < tx_q.size(); k++)
			check8($sformatf("tx byte %0d", k), tx_q[k], exp[31 - 8 * k -: 8]);
		check_cfg();
	endtask

	function automatic cmd_frame_t rand_write();
		cmd_frame_t f;
		f.chan = byte_t'(rand_below(4));
		f.value = rand_byte();
		if (rand_below(2) == 0) begin
			f.op = OP_TRIG_WR;
			f.arg = byte_t'(rand_below(3));
		end else begin
			f.op = OP_VECT_WR;
			f.arg = rand_byte();
		end
		return f;
	endfunction

	function automatic cmd_frame_t rand_invalid();
		cmd_frame_t f;
		byte_t ops [4];
		ops = '{OP_TRIG_WR, OP_TRIG_RD, OP_VECT_WR, OP_VECT_RD};
		f = {ops[rand_below(4)], byte_t'(rand_below(4)), rand_byte(), rand_byte()};
		case (rand_below(3))
			0: begin
				f.op = rand_byte();
				if (f.op inside {OP_TRIG_WR, OP_TRIG_RD, OP_VECT_WR, OP_VECT_RD})
					f.op = 8'h01;
			end
			1: f.chan = byte_t'(4 + rand_below(252));
			default: begin
				f.op = OP_TRIG_WR;
				f.arg = 8'd3;
			end
		endcase
		return f;
	endfunction

	initial begin
		cmd_frame_t f;
		nrst = 1'b0;
		rx = 1'b1;
		baud = 2'd3;
		for (int i = 0; i < 4; i++) begin
			m_type[i] = 2'd3;
			m_level[i] = 8'h00;
			m_vect[i] = 8'h00;
		end
		repeat (8) @(posedge clk);
		nrst <= 1'b1;
		@(posedge clk);

		@(negedge clk);
		check8("tx", 8'(tx), 8'd1);
		check_cfg();
		@(posedge clk);

		for (int n = 0; n < 16; n++)
			do_cmd(rand_write());

		for (int ch = 0; ch < 4; ch++) begin
			do_cmd({OP_TRIG_RD, byte_t'(ch), rand_byte(), rand_byte()});
			do_cmd({OP_VECT_RD, byte_t'(ch), rand_byte(), rand_byte()});
		end

		for (int n = 0; n < 10; n++)
			do_cmd(rand_invalid());

		// two stray bytes, then silence past the gap limit
		send_byte(OP_VECT_WR);
		send_byte(8'h02);
		expect_idle(20 * bit_cycles());
		do_cmd({OP_VECT_WR, 8'h01, 8'h00, rand_byte()});

		for (int sel = 2; sel >= 0; sel--) begin
			baud <= baud_sel_t'(sel);
			@(posedge clk);
			f = rand_write();
			do_cmd(f);
			f.op = (f.op == OP_TRIG_WR) ? OP_TRIG_RD : OP_VECT_RD;
			do_cmd(f);
		end

		$display("checks %0d, check errors %0d, assertion errors %0d",
			checks, errors, u_dut.u_ctrl.u_asserts.fail_cnt);
		if (errors == 0 && u_dut.u_ctrl.u_asserts.fail_cnt == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire
